// ==== design/if_macros.svh ====
//////////////////////////////
// fetch stage widths, queue depth and fixed targets
// include wherever one of these constants is needed
//////////////////////////////

`ifndef IF_MACROS_SVH
`define IF_MACROS_SVH

// address and instruction word width
`define IF_ADDR_W 32

// number of elastic slots between bus master and IF-ID register
`define IF_QUEUE_DEPTH 3

// debug module entry points
`define IF_DM_HALT_ADDR 32'h1A110800
`define IF_DM_EXC_ADDR 32'h1A110808

// all internal interrupts share this vector
`define IF_NMI_VEC 5'd31

`endif

// ==== design/if_pkg.sv ====
//////////////////////////////
// shared types of the fetch stage
// imported by modules that need the PC select enums or the fetch entry
//////////////////////////////

`include "if_macros.svh"

package if_pkg;

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // kind of exception target
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // one fetched word as it moves through the queue
  typedef struct packed {
    logic [`IF_ADDR_W-1:0] addr;
    logic [`IF_ADDR_W-1:0] instr;
    // bus error on this fetch
    logic                  err;
  } fetch_entry_t;

endpackage

// ==== design/fetch_stream_if.sv ====
//////////////////////////////
// valid/ready link carrying one fetch entry
// src drives valid and entry, dst drives ready
//////////////////////////////

`timescale 1ns/10ps

interface fetch_stream_if import if_pkg::*; ();

  // entry offered this cycle
  logic         valid;
  // consumer can take it
  logic         ready;
  // payload, stable while valid and not taken
  fetch_entry_t entry;

  // producer side
  modport src (
    output valid,
    output entry,
    input  ready
  );

  // consumer side
  modport dst (
    input  valid,
    input  entry,
    output ready
  );

endinterface

// ==== design/pc_select.sv ====
//////////////////////////////
// next-PC mux with exception vector computation
// purely combinational, feeds the bus master on pc_set
//////////////////////////////

`timescale 1ns/10ps

`include "if_macros.svh"

module pc_select import if_pkg::*; (
  input  logic                  pc_set_i,
  input  pc_sel_e               pc_mux_i,
  input  exc_pc_sel_e           exc_pc_mux_i,
  input  logic                  exc_irq_int_i,
  input  logic [4:0]            exc_irq_vec_i,
  input  logic [`IF_ADDR_W-1:0] boot_addr_i,
  input  logic [`IF_ADDR_W-1:0] branch_target_i,
  input  logic [`IF_ADDR_W-1:0] csr_mepc_i,
  input  logic [`IF_ADDR_W-1:0] csr_depc_i,
  input  logic [`IF_ADDR_W-1:0] csr_mtvec_i,
  output logic [`IF_ADDR_W-1:0] pc_set_target_o,
  output logic                  csr_mtvec_init_o
);

  logic [4:0]            irq_vec;
  logic [`IF_ADDR_W-1:0] trap_base;
  logic [`IF_ADDR_W-1:0] vec_offset;
  logic [`IF_ADDR_W-1:0] exc_pc;
  logic [`IF_ADDR_W-1:0] fetch_addr;

  // trap base is 256-byte aligned
  assign trap_base = {csr_mtvec_i[`IF_ADDR_W-1:8], 8'h00};

  // internal interrupts all land on the NMI slot
  assign irq_vec = exc_irq_int_i ? `IF_NMI_VEC : exc_irq_vec_i;

  // four bytes per vector entry
  assign vec_offset = {{(`IF_ADDR_W-7){1'b0}}, irq_vec, 2'b00};

  // exception target
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = trap_base;
      EXC_PC_IRQ:     exc_pc = trap_base + vec_offset;
      EXC_PC_DBD:     exc_pc = `IF_DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = `IF_DM_EXC_ADDR;
      default:        exc_pc = trap_base;
    endcase
  end

  // fetch address source
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr = boot_addr_i;
      PC_JUMP: fetch_addr = branch_target_i;
      PC_EXC:  fetch_addr = exc_pc;
      // return from trap
      PC_ERET: fetch_addr = csr_mepc_i;
      // return from debug mode
      PC_DRET: fetch_addr = csr_depc_i;
      default: fetch_addr = boot_addr_i;
    endcase
  end

  // 32-bit only, so targets are always word aligned
  assign pc_set_target_o = {fetch_addr[`IF_ADDR_W-1:2], 2'b00};

  // mtvec is initialised from boot_addr on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// ==== design/instr_bus_fetch.sv ====
//////////////////////////////
// single-outstanding instruction bus master
// fetches sequential words after each pc_set, pushes them into the queue
//////////////////////////////

`timescale 1ns/10ps

`include "if_macros.svh"

module instr_bus_fetch import if_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic                  pc_set_i,
  input  logic [`IF_ADDR_W-1:0] pc_set_target_i,
  output logic                  instr_req_o,
  output logic [`IF_ADDR_W-1:0] instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [`IF_ADDR_W-1:0] instr_rdata_i,
  input  logic                  instr_err_i,
  output logic                  busy_o,
  fetch_stream_if.src           out
);

  logic                  started_q;
  logic                  req_q;
  logic                  req_d;
  logic                  outst_q;
  logic                  outst_d;
  logic                  discard_q;
  logic                  discard_d;
  logic                  resp_valid_q;
  logic                  resp_valid_d;
  fetch_entry_t          resp_q;
  logic [`IF_ADDR_W-1:0] next_addr_q;
  logic [`IF_ADDR_W-1:0] req_addr_q;
  logic [`IF_ADDR_W-1:0] target;
  logic                  gnt_acc;
  logic                  rvalid_acc;
  logic                  req_hold;
  logic                  push;
  logic                  issue;

  //////////////////////////////
  // request control
  //////////////////////////////

  assign target     = {pc_set_target_i[`IF_ADDR_W-1:2], 2'b00};
  assign gnt_acc    = req_q & instr_gnt_i;
  assign rvalid_acc = outst_q & instr_rvalid_i;
  // request not yet granted must stay up with the same address
  assign req_hold   = req_q & ~instr_gnt_i;
  assign outst_d    = (outst_q & ~instr_rvalid_i) | gnt_acc;

  // stale responses never reach the queue
  assign push = rvalid_acc & ~discard_q & ~pc_set_i;

  always_comb begin
    discard_d = discard_q;
    if (pc_set_i) begin
      // whatever is still on the bus belongs to the old stream
      discard_d = req_hold | outst_d;
    end else if (rvalid_acc) begin
      discard_d = 1'b0;
    end
  end

  // response register, flushed together with the queue
  always_comb begin
    resp_valid_d = resp_valid_q & ~out.ready;
    if (pc_set_i) begin
      resp_valid_d = 1'b0;
    end else if (push) begin
      resp_valid_d = 1'b1;
    end
  end

  // new word only when bus is idle and the response register will be free
  assign issue = (started_q | pc_set_i) & req_i & ~req_hold & ~outst_d & ~resp_valid_d;
  assign req_d = req_hold | issue;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q    <= 1'b0;
      req_q        <= 1'b0;
      outst_q      <= 1'b0;
      discard_q    <= 1'b0;
      resp_valid_q <= 1'b0;
      next_addr_q  <= '0;
      req_addr_q   <= '0;
    end else begin
      started_q    <= started_q | pc_set_i;
      req_q        <= req_d;
      outst_q      <= outst_d;
      discard_q    <= discard_d;
      resp_valid_q <= resp_valid_d;
      // redirect wins over the sequential increment
      if (pc_set_i) begin
        next_addr_q <= target;
      end else if (gnt_acc && !discard_q) begin
        next_addr_q <= req_addr_q + 'd4;
      end
      if (issue) begin
        req_addr_q <= pc_set_i ? target : next_addr_q;
      end
    end
  end

  //////////////////////////////
  // response capture
  //////////////////////////////

  // req_addr_q still holds the granted address until the next issue
  always_ff @(posedge clk_i) begin
    if (push) begin
      resp_q.addr  <= req_addr_q;
      resp_q.instr <= instr_rdata_i;
      resp_q.err   <= instr_err_i;
    end
  end

  assign out.valid    = resp_valid_q;
  assign out.entry    = resp_q;
  assign instr_req_o  = req_q;
  assign instr_addr_o = req_addr_q;
  assign busy_o       = req_q | outst_q;

endmodule

// ==== design/fetch_queue_slot.sv ====
//////////////////////////////
// one elastic register stage of the fetch queue
// chain several for a deeper queue, flush empties it at once
//////////////////////////////

`timescale 1ns/10ps

module fetch_queue_slot import if_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  fetch_stream_if.dst  in,
  fetch_stream_if.src  out
);

  logic         full_q;
  logic         take;
  fetch_entry_t data_q;

  // room when empty or when the held entry leaves this cycle
  assign in.ready = ~full_q | out.ready;
  assign take     = in.valid & in.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (flush_i) begin
      // redirect drops anything buffered
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= 1'b1;
    end else if (out.ready) begin
      full_q <= 1'b0;
    end
  end

  // payload only moves on a take
  always_ff @(posedge clk_i) begin
    if (take) begin
      data_q <= in.entry;
    end
  end

  assign out.valid = full_q;
  assign out.entry = data_q;

endmodule

// ==== design/if_id_reg.sv ====
//////////////////////////////
// IF-ID pipeline register
// pops the queue head when ID is ready, holds valid until ID clears it
//////////////////////////////

`timescale 1ns/10ps

`include "if_macros.svh"

module if_id_reg (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  pc_set_i,
  input  logic                  id_in_ready_i,
  input  logic                  instr_valid_clear_i,
  fetch_stream_if.dst           in,
  output logic                  instr_valid_id_o,
  output logic                  instr_new_id_o,
  output logic [`IF_ADDR_W-1:0] instr_rdata_id_o,
  output logic                  instr_fetch_err_o,
  output logic [`IF_ADDR_W-1:0] pc_id_o,
  output logic [`IF_ADDR_W-1:0] pc_if_o
);

  logic accept;
  logic valid_q;
  logic new_q;

  // ID stage paces the whole queue
  assign in.ready = id_in_ready_i;

  // a redirect in the same cycle squashes the head
  assign accept = in.valid & id_in_ready_i & ~pc_set_i;

  // address of the word waiting at the queue head
  assign pc_if_o = in.entry.addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      // valid stays until ID explicitly clears it
      valid_q <= accept | (valid_q & ~instr_valid_clear_i);
      // one cycle pulse per new instruction
      new_q   <= accept;
    end
  end

  // instruction payload, frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      instr_rdata_id_o  <= in.entry.instr;
      instr_fetch_err_o <= in.entry.err;
      pc_id_o           <= in.entry.addr;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

// ==== design/if_stage_top.sv ====
//////////////////////////////
// instruction fetch stage top level
// PC select, bus master, fetch queue and IF-ID register wired together
//////////////////////////////

`timescale 1ns/10ps

`include "if_macros.svh"

module if_stage_top import if_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic [`IF_ADDR_W-1:0] boot_addr_i,
  // instruction bus
  output logic                  instr_req_o,
  output logic [`IF_ADDR_W-1:0] instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [`IF_ADDR_W-1:0] instr_rdata_i,
  input  logic                  instr_err_i,
  // redirect control
  input  logic                  pc_set_i,
  input  pc_sel_e               pc_mux_i,
  input  exc_pc_sel_e           exc_pc_mux_i,
  input  logic                  exc_irq_int_i,
  input  logic [4:0]            exc_irq_vec_i,
  input  logic [`IF_ADDR_W-1:0] branch_target_i,
  input  logic [`IF_ADDR_W-1:0] csr_mepc_i,
  input  logic [`IF_ADDR_W-1:0] csr_depc_i,
  input  logic [`IF_ADDR_W-1:0] csr_mtvec_i,
  output logic                  csr_mtvec_init_o,
  output logic [`IF_ADDR_W-1:0] pc_set_target_o,
  // ID side
  input  logic                  id_in_ready_i,
  input  logic                  instr_valid_clear_i,
  output logic                  instr_valid_id_o,
  output logic                  instr_new_id_o,
  output logic [`IF_ADDR_W-1:0] instr_rdata_id_o,
  output logic                  instr_fetch_err_o,
  output logic [`IF_ADDR_W-1:0] pc_id_o,
  output logic [`IF_ADDR_W-1:0] pc_if_o,
  output logic                  if_busy_o
);

  // link 0 leaves the bus master, the last one feeds IF-ID
  fetch_stream_if stream_if [0:`IF_QUEUE_DEPTH] ();

  pc_select pc_select_i (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_irq_int_i    (exc_irq_int_i),
    .exc_irq_vec_i    (exc_irq_vec_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .pc_set_target_o  (pc_set_target_o),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  instr_bus_fetch bus_fetch_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .pc_set_i        (pc_set_i),
    .pc_set_target_i (pc_set_target_o),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_err_i     (instr_err_i),
    .busy_o          (if_busy_o),
    .out             (stream_if[0])
  );

  //////////////////////////////
  // fetch queue
  //////////////////////////////

  for (genvar i = 0; i < `IF_QUEUE_DEPTH; i++) begin : g_queue
    fetch_queue_slot slot_i (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .flush_i (pc_set_i),
      .in      (stream_if[i]),
      .out     (stream_if[i+1])
    );
  end

  if_id_reg if_id_reg_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .pc_set_i            (pc_set_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .in                  (stream_if[`IF_QUEUE_DEPTH]),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_if_o             (pc_if_o)
  );

endmodule

// ==== verif/instr_mem_model.sv ====
//////////////////////////////
// instruction bus responder for the fetch stage testbench
// random grant and response delays, data follows the address
//////////////////////////////

`timescale 1ns/10ps

module instr_mem_model (
  input  logic        clk_i,
  input  logic        rst_ni,
  // fresh random bits every cycle, [1:0] grant delay, [3:2] response delay
  input  logic [3:0]  rnd_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  logic [1:0]  gnt_cnt_q;
  logic [1:0]  rsp_cnt_q;
  logic        pend_q;
  logic [31:0] addr_q;

  // grant once the delay counter has run down
  assign gnt_o    = req_i && (gnt_cnt_q == 2'd0);
  assign rvalid_o = pend_q && (rsp_cnt_q == 2'd0);

  // data and error region rules
  assign rdata_o  = addr_q ^ 32'hA5A50000;
  assign err_o    = (addr_q[15:12] == 4'hE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_cnt_q <= 2'd0;
      rsp_cnt_q <= 2'd0;
      pend_q    <= 1'b0;
      addr_q    <= '0;
    end else begin
      // count down while a request waits, else load the next delay
      if (req_i && !gnt_o) begin
        gnt_cnt_q <= gnt_cnt_q - 2'd1;
      end else begin
        gnt_cnt_q <= rnd_i[1:0];
      end
      // one response per grant, at least one cycle later
      if (gnt_o) begin
        pend_q    <= 1'b1;
        rsp_cnt_q <= rnd_i[3:2];
        addr_q    <= addr_i;
      end else if (rvalid_o) begin
        pend_q <= 1'b0;
      end else if (pend_q) begin
        rsp_cnt_q <= rsp_cnt_q - 2'd1;
      end
    end
  end

endmodule

// ==== verif/if_stage_tb.sv ====
//////////////////////////////
// testbench for the fetch stage top level
// applies a table of redirects and checks the instruction stream at ID
//////////////////////////////

`timescale 1ns/10ps

module if_stage_tb import if_pkg::*; ();

  localparam int NUM_ROWS = 11;
  localparam logic [31:0] BOOT_ADDR = 32'h0000_1080;

  // one redirect and the words expected after it
  typedef struct packed {
    pc_sel_e     mux;
    exc_pc_sel_e exc;
    logic        irq_int;
    logic [4:0]  irq_vec;
    logic [31:0] csr_val;
    logic [31:0] exp_target;
    logic [7:0]  count;
    logic        exp_err;
    logic        stall;
  } row_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic req_i;
  logic [31:0] boot_addr_i;
  logic instr_req_o;
  logic [31:0] instr_addr_o;
  logic instr_gnt_i;
  logic instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic instr_err_i;
  logic pc_set_i;
  pc_sel_e pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  logic exc_irq_int_i;
  logic [4:0] exc_irq_vec_i;
  logic [31:0] branch_target_i;
  logic [31:0] csr_mepc_i;
  logic [31:0] csr_depc_i;
  logic [31:0] csr_mtvec_i;
  logic csr_mtvec_init_o;
  logic [31:0] pc_set_target_o;
  logic id_in_ready_i;
  logic instr_valid_clear_i;
  logic instr_valid_id_o;
  logic instr_new_id_o;
  logic [31:0] instr_rdata_id_o;
  logic instr_fetch_err_o;
  logic [31:0] pc_id_o;
  logic [31:0] pc_if_o;
  logic if_busy_o;

  logic [31:0] lfsr_q = 32'h7a4f;
  // bits 3:0 set the bus delays and bit 4 the ID ready
  logic [4:0]  rnd_q = '0;
  row_t        rows [NUM_ROWS];
  string       names [NUM_ROWS];
  int          row_cnt = 0;
  int          err_cnt = 0;

  // 4 ns clock
  always #2 clk_i = ~clk_i;

  if_stage_top dut_i (
    .clk_i, .rst_ni, .req_i, .boot_addr_i,
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i, .instr_err_i,
    .pc_set_i, .pc_mux_i, .exc_pc_mux_i, .exc_irq_int_i, .exc_irq_vec_i,
    .branch_target_i, .csr_mepc_i, .csr_depc_i, .csr_mtvec_i,
    .csr_mtvec_init_o, .pc_set_target_o,
    .id_in_ready_i, .instr_valid_clear_i, .instr_valid_id_o, .instr_new_id_o,
    .instr_rdata_id_o, .instr_fetch_err_o, .pc_id_o, .pc_if_o, .if_busy_o
  );

  instr_mem_model mem_i (
    .clk_i, .rst_ni, .rnd_i (rnd_q[3:0]),
    .req_i (instr_req_o), .addr_i (instr_addr_o), .gnt_o (instr_gnt_i),
    .rvalid_o (instr_rvalid_i), .rdata_o (instr_rdata_i), .err_o (instr_err_i)
  );

  //////////////////////////////
  // random source
  //////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per random bit taken
  always @(posedge clk_i) begin : rnd_gen
    logic [31:0] s;
    logic [4:0]  v;
    s = lfsr_q;
    for (int i = 0; i < 5; i++) begin
      s    = lfsr_next(s);
      v[i] = s[0];
    end
    lfsr_q <= s;
    rnd_q  <= v;
  end

  task automatic compare(input string tname, input string what,
                         input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s %s: expected %h, actual %h", tname, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic add_row(input string name, input pc_sel_e mux, input exc_pc_sel_e exc,
                         input logic irq_int, input logic [4:0] irq_vec,
                         input logic [31:0] csr_val, input logic [31:0] exp_target,
                         input int count, input logic exp_err, input logic stall);
    names[row_cnt] = name;
    rows[row_cnt]  = {mux, exc, irq_int, irq_vec, csr_val, exp_target, count[7:0],
                      exp_err, stall};
    row_cnt++;
  endtask

  initial begin : main
    int got;
    int cycles;
    int limit;
    int errs_before;
    int failed_tests;
    logic clear_now;
    logic [31:0] exp_addr;
    logic [31:0] head_addr;
    failed_tests = 0;
    rst_ni <= 1'b0;
    req_i <= 1'b1;
    boot_addr_i <= BOOT_ADDR;
    pc_set_i <= 1'b0;
    pc_mux_i <= PC_BOOT;
    exc_pc_mux_i <= EXC_PC_EXC;
    exc_irq_int_i <= 1'b0;
    exc_irq_vec_i <= 5'd0;
    branch_target_i <= '0;
    csr_mepc_i <= '0;
    csr_depc_i <= '0;
    csr_mtvec_i <= '0;
    id_in_ready_i <= 1'b1;
    instr_valid_clear_i <= 1'b0;
    // expected targets follow the vector and alignment rules by hand
    add_row("boot", PC_BOOT, EXC_PC_EXC, 1'b0, 5'd0, 32'h0, BOOT_ADDR, 4, 1'b0, 1'b0);
    add_row("jump", PC_JUMP, EXC_PC_EXC, 1'b0, 5'd0, 32'h2346, 32'h2344, 3, 1'b0, 1'b0);
    add_row("exc", PC_EXC, EXC_PC_EXC, 1'b0, 5'd0, 32'h3A41, 32'h3A00, 2, 1'b0, 1'b0);
    add_row("irq_vec", PC_EXC, EXC_PC_IRQ, 1'b0, 5'd5, 32'h3A41, 32'h3A14, 2, 1'b0, 1'b0);
    add_row("irq_int", PC_EXC, EXC_PC_IRQ, 1'b1, 5'd5, 32'h3A41, 32'h3A7C, 2, 1'b0, 1'b0);
    add_row("dbg_halt", PC_EXC, EXC_PC_DBD, 1'b0, 5'd0, 32'h0, 32'h1A110800, 2, 1'b0, 1'b0);
    add_row("dbg_exc", PC_EXC, EXC_PC_DBG_EXC, 1'b0, 5'd0, 32'h0, 32'h1A110808, 2, 1'b0, 1'b0);
    add_row("mret", PC_ERET, EXC_PC_EXC, 1'b0, 5'd0, 32'h5003, 32'h5000, 2, 1'b0, 1'b0);
    add_row("dret", PC_DRET, EXC_PC_EXC, 1'b0, 5'd0, 32'h6101, 32'h6100, 2, 1'b0, 1'b0);
    add_row("bus_err", PC_JUMP, EXC_PC_EXC, 1'b0, 5'd0, 32'hE010, 32'hE010, 3, 1'b1, 1'b0);
    add_row("backpressure", PC_JUMP, EXC_PC_EXC, 1'b0, 5'd0, 32'h7000, 32'h7000, 12, 1'b0, 1'b1);
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // no fetch activity before the first redirect
    errs_before = err_cnt;
    repeat (3) begin
      @(negedge clk_i);
      compare("reset", "instr_req_o", 32'd0, instr_req_o);
      compare("reset", "if_busy_o", 32'd0, if_busy_o);
      compare("reset", "instr_valid_id_o", 32'd0, instr_valid_id_o);
      compare("reset", "instr_new_id_o", 32'd0, instr_new_id_o);
    end
    $display("test %-12s %0d errors", "reset", err_cnt - errs_before);
    if (err_cnt != errs_before) failed_tests++;

    for (int r = 0; r < NUM_ROWS; r++) begin
      errs_before = err_cnt;
      @(posedge clk_i);
      pc_set_i <= 1'b1;
      pc_mux_i <= rows[r].mux;
      exc_pc_mux_i <= rows[r].exc;
      exc_irq_int_i <= rows[r].irq_int;
      exc_irq_vec_i <= rows[r].irq_vec;
      branch_target_i <= rows[r].csr_val;
      csr_mepc_i <= rows[r].csr_val;
      csr_depc_i <= rows[r].csr_val;
      csr_mtvec_i <= rows[r].csr_val;
      instr_valid_clear_i <= 1'b0;
      id_in_ready_i <= 1'b1;
      // target and mtvec init are combinational in the pc_set cycle
      @(negedge clk_i);
      compare(names[r], "pc_set_target_o", rows[r].exp_target, pc_set_target_o);
      compare(names[r], "csr_mtvec_init_o", rows[r].mux == PC_BOOT, csr_mtvec_init_o);
      head_addr = pc_if_o;
      @(posedge clk_i);
      pc_set_i <= 1'b0;

      //////////////////////////////
      // consume the new stream
      //////////////////////////////
      got = 0;
      cycles = 0;
      limit = 64 + 16 * rows[r].count;
      while (got < rows[r].count && cycles < limit) begin
        @(negedge clk_i);
        cycles++;
        clear_now = instr_new_id_o;
        if (instr_new_id_o) begin
          exp_addr = rows[r].exp_target + 32'(4 * got);
          compare(names[r], "pc_id_o", exp_addr, pc_id_o);
          // the accepted word sat at the queue head one cycle earlier
          compare(names[r], "pc_if_o", exp_addr, head_addr);
          compare(names[r], "instr_rdata_id_o", exp_addr ^ 32'hA5A50000, instr_rdata_id_o);
          compare(names[r], "instr_fetch_err_o", rows[r].exp_err, instr_fetch_err_o);
          compare(names[r], "instr_valid_id_o", 32'd1, instr_valid_id_o);
          got++;
        end
        head_addr = pc_if_o;
        @(posedge clk_i);
        // clear right after each accept and stall ID at random where the row asks
        instr_valid_clear_i <= clear_now;
        id_in_ready_i <= rows[r].stall ? rnd_q[4] : 1'b1;
      end
      if (got < rows[r].count) begin
        $display("Error: test %s timed out after %0d cycles with %0d of %0d instructions",
                 names[r], cycles, got, rows[r].count);
        err_cnt++;
      end
      $display("test %-12s %0d errors", names[r], err_cnt - errs_before);
      if (err_cnt != errs_before) failed_tests++;
    end

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             NUM_ROWS + 1, NUM_ROWS + 1 - failed_tests, failed_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+design
design/if_pkg.sv
design/fetch_stream_if.sv
design/pc_select.sv
design/instr_bus_fetch.sv
design/fetch_queue_slot.sv
design/if_id_reg.sv
design/if_stage_top.sv
verif/instr_mem_model.sv
verif/if_stage_tb.sv

// ==== Bender.yml ====
package:
  name: if_stage

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/if_pkg.sv
      - design/fetch_stream_if.sv
      - design/pc_select.sv
      - design/instr_bus_fetch.sv
      - design/fetch_queue_slot.sv
      - design/if_id_reg.sv
      - design/if_stage_top.sv
  - target: test
    files:
      - verif/instr_mem_model.sv
      - verif/if_stage_tb.sv
